// ==== hdl/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    parameter int ID_W = 4;
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // sideband fields, taken but never decoded
    parameter int LEN_W = 8;
    parameter int SIZE_W = 3;
    parameter int BURST_W = 2;
    parameter int LOCK_W = 2;
    parameter int CACHE_W = 4;
    parameter int PROT_W = 3;
    parameter int STRB_W = DATA_W / 8;

    typedef logic [ID_W-1:0] id_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_RRESP,
        ST_WDATA,
        ST_BRESP
    } port_state_e;

endpackage

`default_nettype wire

// ==== hdl/gpio_pkg.sv ====
`default_nettype none

package gpio_pkg;

    parameter int OFFSET_BITS = 12;

    typedef enum logic [OFFSET_BITS-1:0] {
        REG_SWITCH = 12'h000,
        REG_KEYPAD = 12'h004,
        REG_BICOLOR0 = 12'h008,
        REG_BICOLOR1 = 12'h00C,
        REG_LED = 12'h010,
        REG_NUM = 12'h014,
        REG_TIMER = 12'h018
    } reg_e;

    // bank widths, num is a full data word
    parameter int SWITCH_W = 8;
    parameter int KEYPAD_W = 16;
    parameter int LED_W = 16;
    parameter int BICOLOR_W = 2;

endpackage

`default_nettype wire

// ==== hdl/reg_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;

    logic rd;
    logic wr;
    logic [gpio_pkg::OFFSET_BITS-1:0] offset;
    axi_pkg::data_t wdata;

    // per-block decode and registered read data
    logic gpio_hit;
    axi_pkg::data_t gpio_rdata;
    logic timer_hit;
    axi_pkg::data_t timer_rdata;

    modport master (
        output rd, wr, offset, wdata,
        input gpio_hit, gpio_rdata, timer_hit, timer_rdata
    );

    modport gpio (
        input rd, wr, offset, wdata,
        output gpio_hit, gpio_rdata
    );

    modport timer (
        input rd, wr, offset, wdata,
        output timer_hit, timer_rdata
    );

endinterface

`default_nettype wire

// ==== hdl/axi_slave_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_slave_port (
    input  logic clk,
    input  logic rst,
    input  axi_pkg::id_t arid,
    input  axi_pkg::addr_t araddr,
    input  logic [axi_pkg::LEN_W-1:0] arlen,
    input  logic [axi_pkg::SIZE_W-1:0] arsize,
    input  logic [axi_pkg::BURST_W-1:0] arburst,
    input  logic [axi_pkg::LOCK_W-1:0] arlock,
    input  logic [axi_pkg::CACHE_W-1:0] arcache,
    input  logic [axi_pkg::PROT_W-1:0] arprot,
    input  logic arvalid,
    output logic arready,
    output axi_pkg::id_t rid,
    output axi_pkg::data_t rdata,
    output axi_pkg::resp_e rresp,
    output logic rlast,
    output logic rvalid,
    input  logic rready,
    input  axi_pkg::id_t awid,
    input  axi_pkg::addr_t awaddr,
    input  logic [axi_pkg::LEN_W-1:0] awlen,
    input  logic [axi_pkg::SIZE_W-1:0] awsize,
    input  logic [axi_pkg::BURST_W-1:0] awburst,
    input  logic [axi_pkg::LOCK_W-1:0] awlock,
    input  logic [axi_pkg::CACHE_W-1:0] awcache,
    input  logic [axi_pkg::PROT_W-1:0] awprot,
    input  logic awvalid,
    output logic awready,
    input  axi_pkg::id_t wid,
    input  axi_pkg::data_t wdata,
    input  logic [axi_pkg::STRB_W-1:0] wstrb,
    input  logic wlast,
    input  logic wvalid,
    output logic wready,
    output axi_pkg::id_t bid,
    output axi_pkg::resp_e bresp,
    output logic bvalid,
    input  logic bready,
    reg_bus_if.master bus
);

    axi_pkg::port_state_e state_q;
    axi_pkg::port_state_e state_d;
    axi_pkg::id_t buf_id;
    logic [gpio_pkg::OFFSET_BITS-1:0] buf_offset;
    axi_pkg::resp_e resp_q;
    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic any_hit;

    // read wins when both address channels are valid in idle
    assign arready = (state_q == axi_pkg::ST_IDLE);
    assign awready = (state_q == axi_pkg::ST_IDLE) && !arvalid;
    assign wready = (state_q == axi_pkg::ST_WDATA);

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs = wvalid && wready;
    assign any_hit = bus.gpio_hit || bus.timer_hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            axi_pkg::ST_IDLE: begin
                if (ar_hs) begin
                    state_d = axi_pkg::ST_READ;
                end else if (aw_hs) begin
                    state_d = axi_pkg::ST_WDATA;
                end
            end
            axi_pkg::ST_READ: state_d = axi_pkg::ST_RRESP;
            axi_pkg::ST_RRESP: begin
                if (rready) begin
                    state_d = axi_pkg::ST_IDLE;
                end
            end
            axi_pkg::ST_WDATA: begin
                if (w_hs) begin
                    state_d = axi_pkg::ST_BRESP;
                end
            end
            axi_pkg::ST_BRESP: begin
                if (bready) begin
                    state_d = axi_pkg::ST_IDLE;
                end
            end
            default: state_d = axi_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= axi_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request buffer, one beat only
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            buf_id <= arid;
            buf_offset <= araddr[gpio_pkg::OFFSET_BITS-1:0];
        end else if (aw_hs) begin
            buf_id <= awid;
            buf_offset <= awaddr[gpio_pkg::OFFSET_BITS-1:0];
        end
    end

    // response code from the decode of the buffered offset
    always_ff @(posedge clk) begin
        if (state_q == axi_pkg::ST_READ || w_hs) begin
            resp_q <= any_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
    end

    assign bus.rd = (state_q == axi_pkg::ST_READ);
    assign bus.wr = w_hs;
    assign bus.offset = buf_offset;
    assign bus.wdata = wdata;

    // blocks hold their rdata until the next rd, so no extra capture
    assign rdata = bus.gpio_rdata | bus.timer_rdata;
    assign rid = buf_id;
    assign rresp = resp_q;
    assign rvalid = (state_q == axi_pkg::ST_RRESP);
    assign rlast = rvalid;

    assign bid = buf_id;
    assign bresp = resp_q;
    assign bvalid = (state_q == axi_pkg::ST_BRESP);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst)
        !(bus.rd && bus.wr));

    a_resp_excl: assert property (@(posedge clk) disable iff (!rst)
        !(rvalid && bvalid));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== hdl/gpio_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpio_regs #(
    parameter logic [gpio_pkg::LED_W-1:0] LED_INIT = '1
) (
    input  logic clk,
    input  logic rst,
    input  logic [gpio_pkg::SWITCH_W-1:0] switch,
    input  logic [gpio_pkg::KEYPAD_W-1:0] keypad,
    output logic [gpio_pkg::BICOLOR_W-1:0] bicolor_led_0,
    output logic [gpio_pkg::BICOLOR_W-1:0] bicolor_led_1,
    output logic [gpio_pkg::LED_W-1:0] led,
    output axi_pkg::data_t num,
    reg_bus_if.gpio bus
);

    assign bus.gpio_hit = bus.offset inside {
        gpio_pkg::REG_SWITCH, gpio_pkg::REG_KEYPAD,
        gpio_pkg::REG_BICOLOR0, gpio_pkg::REG_BICOLOR1,
        gpio_pkg::REG_LED, gpio_pkg::REG_NUM
    };

    // input banks are read-only, writes to them fall through
    always_ff @(posedge clk) begin
        if (!rst) begin
            bicolor_led_0 <= '0;
            bicolor_led_1 <= '0;
            led <= LED_INIT;
            num <= '0;
        end else if (bus.wr && bus.gpio_hit) begin
            case (bus.offset)
                gpio_pkg::REG_BICOLOR0: bicolor_led_0 <= bus.wdata[gpio_pkg::BICOLOR_W-1:0];
                gpio_pkg::REG_BICOLOR1: bicolor_led_1 <= bus.wdata[gpio_pkg::BICOLOR_W-1:0];
                gpio_pkg::REG_LED: led <= bus.wdata[gpio_pkg::LED_W-1:0];
                gpio_pkg::REG_NUM: num <= bus.wdata;
                default: ;
            endcase
        end
    end

    // switch and keypad sampled here
    always_ff @(posedge clk) begin
        if (bus.rd) begin
            case (bus.offset)
                gpio_pkg::REG_SWITCH: bus.gpio_rdata <= axi_pkg::data_t'(switch);
                gpio_pkg::REG_KEYPAD: bus.gpio_rdata <= axi_pkg::data_t'(keypad);
                gpio_pkg::REG_BICOLOR0: bus.gpio_rdata <= axi_pkg::data_t'(bicolor_led_0);
                gpio_pkg::REG_BICOLOR1: bus.gpio_rdata <= axi_pkg::data_t'(bicolor_led_1);
                gpio_pkg::REG_LED: bus.gpio_rdata <= axi_pkg::data_t'(led);
                gpio_pkg::REG_NUM: bus.gpio_rdata <= num;
                default: bus.gpio_rdata <= '0;
            endcase
        end
    end

    a_out_on_wr: assert property (@(posedge clk) disable iff (!rst)
        $changed({bicolor_led_0, bicolor_led_1, led, num}) |-> $past(bus.wr));

endmodule

`default_nettype wire

// ==== hdl/sys_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module sys_timer #(
    parameter axi_pkg::data_t TIMER_INIT = '0
) (
    input  logic clk,
    input  logic rst,
    reg_bus_if.timer bus
);

    axi_pkg::data_t count;

    assign bus.timer_hit = (bus.offset == gpio_pkg::REG_TIMER);

    // a load replaces the increment on that edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= TIMER_INIT;
        end else if (bus.wr && bus.timer_hit) begin
            count <= bus.wdata;
        end else begin
            count <= count + axi_pkg::data_t'(1);
        end
    end

    // returns the count seen before the rd edge
    always_ff @(posedge clk) begin
        if (bus.rd) begin
            bus.timer_rdata <= bus.timer_hit ? count : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gpio_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpio_top #(
    parameter logic [gpio_pkg::LED_W-1:0] LED_INIT = '1,
    parameter axi_pkg::data_t TIMER_INIT = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic [axi_pkg::ID_W-1:0] arid,
    input  logic [axi_pkg::ADDR_W-1:0] araddr,
    input  logic [axi_pkg::LEN_W-1:0] arlen,
    input  logic [axi_pkg::SIZE_W-1:0] arsize,
    input  logic [axi_pkg::BURST_W-1:0] arburst,
    input  logic [axi_pkg::LOCK_W-1:0] arlock,
    input  logic [axi_pkg::CACHE_W-1:0] arcache,
    input  logic [axi_pkg::PROT_W-1:0] arprot,
    input  logic arvalid,
    output logic arready,
    output logic [axi_pkg::ID_W-1:0] rid,
    output logic [axi_pkg::DATA_W-1:0] rdata,
    output logic [1:0] rresp,
    output logic rlast,
    output logic rvalid,
    input  logic rready,
    input  logic [axi_pkg::ID_W-1:0] awid,
    input  logic [axi_pkg::ADDR_W-1:0] awaddr,
    input  logic [axi_pkg::LEN_W-1:0] awlen,
    input  logic [axi_pkg::SIZE_W-1:0] awsize,
    input  logic [axi_pkg::BURST_W-1:0] awburst,
    input  logic [axi_pkg::LOCK_W-1:0] awlock,
    input  logic [axi_pkg::CACHE_W-1:0] awcache,
    input  logic [axi_pkg::PROT_W-1:0] awprot,
    input  logic awvalid,
    output logic awready,
    input  logic [axi_pkg::ID_W-1:0] wid,
    input  logic [axi_pkg::DATA_W-1:0] wdata,
    input  logic [axi_pkg::STRB_W-1:0] wstrb,
    input  logic wlast,
    input  logic wvalid,
    output logic wready,
    output logic [axi_pkg::ID_W-1:0] bid,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [gpio_pkg::SWITCH_W-1:0] switch,
    input  logic [gpio_pkg::KEYPAD_W-1:0] keypad,
    output logic [gpio_pkg::BICOLOR_W-1:0] bicolor_led_0,
    output logic [gpio_pkg::BICOLOR_W-1:0] bicolor_led_1,
    output logic [gpio_pkg::LED_W-1:0] led,
    output logic [axi_pkg::DATA_W-1:0] num
);

    reg_bus_if bus ();

    // AXI port names match one to one
    axi_slave_port u_axi (.*);

    gpio_regs #(
        .LED_INIT(LED_INIT)
    ) u_gpio (
        .clk(clk),
        .rst(rst),
        .switch(switch),
        .keypad(keypad),
        .bicolor_led_0(bicolor_led_0),
        .bicolor_led_1(bicolor_led_1),
        .led(led),
        .num(num),
        .bus(bus)
    );

    sys_timer #(
        .TIMER_INIT(TIMER_INIT)
    ) u_timer (
        .clk(clk),
        .rst(rst),
        .bus(bus)
    );

endmodule

`default_nettype wire

// ==== sim/gpio_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpio_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 5;
    localparam int BANK_ROUNDS = 8;
    localparam int INPUT_ROUNDS = 8;
    localparam int TIMER_ROUNDS = 4;
    localparam int BAD_ROUNDS = 4;
    // a transaction with the longest stall stays under 20 cycles
    localparam int TXN_COUNT = BANK_ROUNDS * 8 + INPUT_ROUNDS * 2 + TIMER_ROUNDS * 2
        + BAD_ROUNDS * 2 + 2;
    localparam int MAX_CYCLES = RESET_CYCLES + TXN_COUNT * 20;
    localparam logic [31:0] BASE = 32'h4000_0000;

    logic clk = 1'b0;
    logic rst;
    axi_pkg::id_t arid, rid, awid, wid, bid;
    axi_pkg::addr_t araddr, awaddr;
    axi_pkg::data_t rdata, wdata, num;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize, arprot, awprot;
    logic [1:0] arburst, awburst, arlock, awlock, rresp, bresp;
    logic [3:0] arcache, awcache, wstrb;
    logic arvalid, arready, rlast, rvalid, rready;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [7:0] switch;
    logic [15:0] keypad, led;
    logic [1:0] bicolor_led_0, bicolor_led_1;

    // expected output banks
    logic [1:0] exp_bic0, exp_bic1;
    logic [15:0] exp_led;
    logic [31:0] exp_num;

    logic [15:0] lfsr = 16'd7798;
    int unsigned edges = 0;
    int unsigned ar_edge_seen, r_edge_seen, aw_edge_seen, w_edge_seen;

    gpio_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) edges <= edges + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
        assert (got === want)
        else abort_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, want));
    endtask

    task automatic check_outputs();
        check_eq(32'(bicolor_led_0), 32'(exp_bic0), "bicolor_led_0");
        check_eq(32'(bicolor_led_1), 32'(exp_bic1), "bicolor_led_1");
        check_eq(32'(led), 32'(exp_led), "led");
        check_eq(num, exp_num, "num");
    endtask

    task automatic model_write(input logic [11:0] off, input logic [31:0] v);
        case (off)
            gpio_pkg::REG_BICOLOR0: exp_bic0 = v[1:0];
            gpio_pkg::REG_BICOLOR1: exp_bic1 = v[1:0];
            gpio_pkg::REG_LED: exp_led = v[15:0];
            gpio_pkg::REG_NUM: exp_num = v;
            default: ;
        endcase
    endtask

    function automatic logic [31:0] expected_read(input logic [11:0] off);
        case (off)
            gpio_pkg::REG_SWITCH: return {24'b0, switch};
            gpio_pkg::REG_KEYPAD: return {16'b0, keypad};
            gpio_pkg::REG_BICOLOR0: return {30'b0, exp_bic0};
            gpio_pkg::REG_BICOLOR1: return {30'b0, exp_bic1};
            gpio_pkg::REG_LED: return {16'b0, exp_led};
            gpio_pkg::REG_NUM: return exp_num;
            default: return '0;
        endcase
    endfunction

    // starts and ends DRIVE_DELAY after a rising edge
    task automatic axi_read(input axi_pkg::id_t id, input axi_pkg::addr_t addr, input int stall,
                            output axi_pkg::data_t data, output logic [1:0] resp,
                            output axi_pkg::id_t id_o);
        arid = id;
        araddr = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        ar_edge_seen = edges + 1;
        @(posedge clk);
        #DRIVE_DELAY;
        arvalid = 1'b0;
        // address bus moves on once taken
        araddr = ~addr;
        repeat (stall) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        rready = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        id_o = rid;
        r_edge_seen = edges + 1;
        @(posedge clk);
        #DRIVE_DELAY;
        rready = 1'b0;
    endtask

    task automatic axi_write(input axi_pkg::id_t id, input axi_pkg::addr_t addr,
                             input axi_pkg::data_t data, input int stall,
                             output logic [1:0] resp, output axi_pkg::id_t id_o);
        awid = id;
        awaddr = addr;
        awvalid = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        aw_edge_seen = edges + 1;
        @(posedge clk);
        #DRIVE_DELAY;
        awvalid = 1'b0;
        awaddr = ~addr;
        wid = id;
        wdata = data;
        wlast = 1'b1;
        wvalid = 1'b1;
        @(negedge clk);
        while (!wready) @(negedge clk);
        w_edge_seen = edges + 1;
        @(posedge clk);
        #DRIVE_DELAY;
        wvalid = 1'b0;
        wlast = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        bready = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        id_o = bid;
        @(posedge clk);
        #DRIVE_DELAY;
        bready = 1'b0;
    endtask

    task automatic write_and_check(input axi_pkg::addr_t addr, input axi_pkg::data_t v,
                                   input logic [1:0] want_resp);
        axi_pkg::id_t id;
        axi_pkg::id_t got;
        logic [1:0] resp;
        int stall;
        id = 4'(rand_bits(4));
        stall = int'(rand_bits(3));
        axi_write(id, addr, v, stall, resp, got);
        check_eq(32'(resp), 32'(want_resp), "bresp");
        check_eq(32'(got), 32'(id), "bid");
        model_write(addr[11:0], v);
        check_outputs();
    endtask

    task automatic read_and_check(input axi_pkg::addr_t addr, input axi_pkg::data_t want,
                                  input logic [1:0] want_resp);
        axi_pkg::id_t id;
        axi_pkg::id_t got;
        axi_pkg::data_t data;
        logic [1:0] resp;
        int stall;
        id = 4'(rand_bits(4));
        stall = int'(rand_bits(3));
        axi_read(id, addr, stall, data, resp, got);
        check_eq(data, want, "rdata");
        check_eq(32'(resp), 32'(want_resp), "rresp");
        check_eq(32'(got), 32'(id), "rid");
    endtask

    a_r_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rid))
        else abort_run($sformatf("Fail %0t: read response moved under back-pressure", $time));

    a_b_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid))
        else abort_run($sformatf("Fail %0t: write response moved under back-pressure", $time));

    a_busy: assert property (@(posedge clk) disable iff (!rst)
        (rvalid || bvalid) |-> !arready && !awready)
        else abort_run($sformatf("Fail %0t: address ready while a response is pending", $time));

    a_read_first: assert property (@(posedge clk) disable iff (!rst)
        arvalid |-> !awready)
        else abort_run($sformatf("Fail %0t: awready high while arvalid is high", $time));

    a_rlast: assert property (@(posedge clk) disable iff (!rst)
        rvalid |-> rlast)
        else abort_run($sformatf("Fail %0t: rlast low with rvalid", $time));

    a_out_stable: assert property (@(posedge clk) disable iff (!rst)
        !(wvalid && wready) |=> $stable({bicolor_led_0, bicolor_led_1, led, num}))
        else abort_run($sformatf("Fail %0t: output bank changed without a write", $time));

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles", MAX_CYCLES));
    end

    initial begin
        logic [31:0] v;
        axi_pkg::data_t data;
        logic [1:0] resp_r;
        logic [1:0] resp_w;
        axi_pkg::id_t id_r;
        axi_pkg::id_t id_w;
        axi_pkg::id_t got_r;
        axi_pkg::id_t got_w;
        int stall;
        logic [11:0] out_regs [4];
        logic [11:0] bad_offs [4];
        out_regs = '{gpio_pkg::REG_LED, gpio_pkg::REG_NUM,
                     gpio_pkg::REG_BICOLOR0, gpio_pkg::REG_BICOLOR1};
        bad_offs = '{12'h01C, 12'h020, 12'h3F0, 12'hFFE};
        rst = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = 3'd2;
        arburst = 2'b01;
        arlock = '0;
        arcache = '0;
        arprot = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = 3'd2;
        awburst = 2'b01;
        awlock = '0;
        awcache = '0;
        awprot = '0;
        awvalid = 1'b0;
        wid = '0;
        wdata = '0;
        wstrb = '1;
        wlast = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        switch = '0;
        keypad = '0;
        exp_bic0 = '0;
        exp_bic1 = '0;
        exp_led = '1;
        exp_num = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        @(negedge clk);
        check_outputs();
        check_eq({27'b0, rvalid, bvalid, wready, arready, awready}, 32'h3,
                 "rvalid, bvalid, wready, arready, awready after reset");
        check_eq(32'(dut_i.u_axi.state_q), 32'(axi_pkg::ST_IDLE), "port state after reset");
        @(posedge clk);
        #DRIVE_DELAY;

        for (int i = 0; i < BANK_ROUNDS; i++) begin
            for (int r = 0; r < 4; r++) begin
                write_and_check(BASE | 32'(out_regs[r]), rand_bits(32), axi_pkg::RESP_OKAY);
            end
            for (int r = 0; r < 4; r++) begin
                read_and_check(BASE | 32'(out_regs[r]), expected_read(out_regs[r]),
                               axi_pkg::RESP_OKAY);
            end
        end

        for (int i = 0; i < INPUT_ROUNDS; i++) begin
            switch = 8'(rand_bits(8));
            keypad = 16'(rand_bits(16));
            read_and_check(BASE | 32'(gpio_pkg::REG_SWITCH),
                           expected_read(gpio_pkg::REG_SWITCH), axi_pkg::RESP_OKAY);
            read_and_check(BASE | 32'(gpio_pkg::REG_KEYPAD),
                           expected_read(gpio_pkg::REG_KEYPAD), axi_pkg::RESP_OKAY);
        end

        // count runs on between the load edge and the edge after AR
        for (int i = 0; i < TIMER_ROUNDS; i++) begin
            v = rand_bits(32);
            write_and_check(BASE | 32'(gpio_pkg::REG_TIMER), v, axi_pkg::RESP_OKAY);
            stall = int'(rand_bits(3));
            repeat (stall) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            id_r = 4'(rand_bits(4));
            stall = int'(rand_bits(3));
            axi_read(id_r, BASE | 32'(gpio_pkg::REG_TIMER), stall, data, resp_r, got_r);
            check_eq(data, v + (ar_edge_seen - w_edge_seen), "timer count");
            check_eq(32'(resp_r), 32'(axi_pkg::RESP_OKAY), "timer rresp");
            check_eq(32'(got_r), 32'(id_r), "timer rid");
        end

        for (int i = 0; i < BAD_ROUNDS; i++) begin
            write_and_check(BASE | 32'(bad_offs[i]), rand_bits(32), axi_pkg::RESP_SLVERR);
            read_and_check(BASE | 32'(bad_offs[i]), 32'h0, axi_pkg::RESP_SLVERR);
        end

        // both address channels raised in the same cycle
        v = rand_bits(32);
        id_r = 4'(rand_bits(4));
        id_w = 4'(rand_bits(4));
        fork
            axi_read(id_r, BASE | 32'(gpio_pkg::REG_LED), 2, data, resp_r, got_r);
            axi_write(id_w, BASE | 32'(gpio_pkg::REG_NUM), v, 2, resp_w, got_w);
        join
        assert (r_edge_seen < aw_edge_seen)
        else abort_run("write address was accepted before the read completed");
        check_eq(data, {16'b0, exp_led}, "led readback beside a write");
        check_eq(32'(resp_r), 32'(axi_pkg::RESP_OKAY), "rresp beside a write");
        check_eq(32'(resp_w), 32'(axi_pkg::RESP_OKAY), "bresp beside a read");
        check_eq(32'(got_r), 32'(id_r), "rid beside a write");
        check_eq(32'(got_w), 32'(id_w), "bid beside a read");
        model_write(gpio_pkg::REG_NUM, v);
        check_outputs();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/axi_pkg.sv
hdl/gpio_pkg.sv
hdl/reg_bus_if.sv
hdl/axi_slave_port.sv
hdl/gpio_regs.sv
hdl/sys_timer.sv
hdl/gpio_top.sv
sim/gpio_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= gpio_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
